//--- egr_cfg_pkg.sv
// Egress fetch path configuration
// Queue count, tag FIFO sizing, APB register map and reset values
// Packet read controller state encoding
`default_nettype none

package egr_cfg_pkg;

    // --------------------
    // Queues and tag FIFOs
    localparam int QUEUE_COUNT    = 4;
    localparam int TAG_FIFO_DEPTH = 4;
    localparam int TAG_PTR_W      = $clog2(TAG_FIFO_DEPTH);
    // One extra bit so a full FIFO can be told apart from an empty one
    localparam int TAG_CNT_W      = $clog2(TAG_FIFO_DEPTH + 1);

    // --------------------
    // APB register offsets
    localparam logic [3:0] REG_QEN      = 4'h0;
    localparam logic [3:0] REG_PKT_CNT  = 4'h4;
    localparam logic [3:0] REG_WORD_CNT = 4'h8;

    // All queues enabled out of reset
    localparam logic [QUEUE_COUNT-1:0] QEN_RESET = '1;

    // Packet read controller states
    typedef enum logic [1:0] {
        wait_fetch,
        get_tag,
        fetch_data,
        fetch_ctrl
    } prc_state_t;

endpackage

`default_nettype wire

//--- egr_types_pkg.sv
// Egress datapath types
// Queue, pointer and count vectors, APB bus widths
// Packet tag and memory read request structs, word type
`default_nettype none

package egr_types_pkg;

    // --------------------
    // Plain vectors
    typedef logic [$clog2(egr_cfg_pkg::QUEUE_COUNT)-1:0] queue_t;
    // One bit per queue
    typedef logic [egr_cfg_pkg::QUEUE_COUNT-1:0] qmask_t;
    typedef logic [11:0] seg_ptr_t;
    // Data words per packet, 1 to 15
    typedef logic [3:0]  wd_cnt_t;
    typedef logic [15:0] stat_cnt_t;
    typedef logic [3:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    typedef enum logic {
        word_data = 1'b0,
        word_ctrl = 1'b1
    } word_type_t;

    // --------------------
    // Tag as pushed into the per-queue FIFOs
    typedef struct packed {
        queue_t   queue;
        seg_ptr_t seg_ptr;
        wd_cnt_t  wd_cnt;
    } tag_t;

    // Word read request toward shared memory
    typedef struct packed {
        seg_ptr_t   seg_ptr;
        wd_cnt_t    wd_sel;     // word index inside the segment
        word_type_t word_type;
        queue_t     queue;
        logic       sop;
        logic       eop;
    } rreq_t;

endpackage

`default_nettype wire

//--- egr_tag_unit.sv
// Tag management for the egress fetch path
// One circular tag FIFO per queue, push by the queue inside the tag
// Head entry and pop selected by queue index, non-empty mask out
`timescale 1ns/1ps
`default_nettype none

module egr_tag_unit (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire egr_types_pkg::tag_t   tag_in,
    input  wire logic                  tag_valid,
    output logic                       tag_ready,
    output egr_types_pkg::qmask_t      nonempty,
    input  wire logic                  pop,
    input  wire egr_types_pkg::queue_t pop_queue,
    output egr_types_pkg::tag_t        head_tag
);

    // Tag storage
    egr_types_pkg::tag_t fifo_mem [egr_cfg_pkg::QUEUE_COUNT][egr_cfg_pkg::TAG_FIFO_DEPTH];

    logic [egr_cfg_pkg::TAG_PTR_W-1:0] rd_ptr [egr_cfg_pkg::QUEUE_COUNT];
    logic [egr_cfg_pkg::TAG_PTR_W-1:0] wr_ptr [egr_cfg_pkg::QUEUE_COUNT];
    logic [egr_cfg_pkg::TAG_CNT_W-1:0] count  [egr_cfg_pkg::QUEUE_COUNT];

    // Low during reset, high from the first edge after it
    logic ready_en;
    logic push;

    // Ready only looks at the queue that the incoming tag addresses
    assign tag_ready = ready_en &&
                       (count[tag_in.queue] != egr_cfg_pkg::TAG_CNT_W'(egr_cfg_pkg::TAG_FIFO_DEPTH));
    assign push      = tag_valid && tag_ready;

    // Head of the queue the controller is looking at
    assign head_tag  = fifo_mem[pop_queue][rd_ptr[pop_queue]];

    always_comb begin
        for (int q = 0; q < egr_cfg_pkg::QUEUE_COUNT; q++) begin
            nonempty[q] = (count[q] != '0);
        end
    end

    // --------------------
    // Pointers and counts
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ready_en <= 1'b0;
            for (int q = 0; q < egr_cfg_pkg::QUEUE_COUNT; q++) begin
                rd_ptr[q] <= '0;
                wr_ptr[q] <= '0;
                count[q]  <= '0;
            end
        end else begin
            ready_en <= 1'b1;
            for (int q = 0; q < egr_cfg_pkg::QUEUE_COUNT; q++) begin
                // Push and pop on the same queue leave the count as is
                if (push && tag_in.queue == q) begin
                    wr_ptr[q] <= wr_ptr[q] + 1'b1;
                end
                if (pop && pop_queue == q) begin
                    rd_ptr[q] <= rd_ptr[q] + 1'b1;
                end
                if ((push && tag_in.queue == q) && !(pop && pop_queue == q)) begin
                    count[q] <= count[q] + 1'b1;
                end else if (!(push && tag_in.queue == q) && (pop && pop_queue == q)) begin
                    count[q] <= count[q] - 1'b1;
                end
            end
        end
    end

    // Write the tag into its own queue
    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[tag_in.queue][wr_ptr[tag_in.queue]] <= tag_in;
        end
    end

endmodule

`default_nettype wire

//--- egr_fetch_sched.sv
// Packet fetch scheduler
// Round-robin pick among queues that are non-empty and enabled
// One grant at a time toward the packet read controller
`timescale 1ns/1ps
`default_nettype none

module egr_fetch_sched (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire egr_types_pkg::qmask_t nonempty,
    input  wire egr_types_pkg::qmask_t qen,
    output logic                       grant_valid,
    output egr_types_pkg::queue_t      grant_queue,
    input  wire logic                  grant_ready
);

    // Last queue granted, search starts one past it
    egr_types_pkg::queue_t last_q_r;

    egr_types_pkg::qmask_t eligible;

    assign eligible = nonempty & qen;

    // --------------------
    // Round-robin search
    always_comb begin
        egr_types_pkg::queue_t idx;
        logic                  found;

        found       = 1'b0;
        grant_queue = last_q_r;
        for (int i = 1; i <= egr_cfg_pkg::QUEUE_COUNT; i++) begin
            idx = egr_types_pkg::queue_t'((int'(last_q_r) + i) % egr_cfg_pkg::QUEUE_COUNT);
            // First eligible queue in rotation order wins
            if (!found && eligible[idx]) begin
                found       = 1'b1;
                grant_queue = idx;
            end
        end
        grant_valid = found;
    end

    // Pointer moves only on an accepted grant
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // Points at the last queue so queue 0 is served first
            last_q_r <= egr_types_pkg::queue_t'(egr_cfg_pkg::QUEUE_COUNT - 1);
        end else if (grant_valid && grant_ready) begin
            last_q_r <= grant_queue;
        end
    end

endmodule

`default_nettype wire

//--- prc.sv
// Packet read controller
// Takes a granted queue, pops its head tag and walks the packet
// One read request per data word, then one control word request
`timescale 1ns/1ps
`default_nettype none

module prc (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  grant_valid,
    input  wire egr_types_pkg::queue_t grant_queue,
    output logic                       grant_ready,
    output logic                       pop,
    output egr_types_pkg::queue_t      pop_queue,
    input  wire egr_types_pkg::tag_t   head_tag,
    output egr_types_pkg::rreq_t       rreq,
    output logic                       rreq_valid,
    input  wire logic                  rreq_ready,
    output logic                       pkt_done,
    output logic                       word_done
);

    egr_cfg_pkg::prc_state_t state_r;

    // Packet context, latched from grant and tag
    egr_types_pkg::queue_t   queue_r;
    egr_types_pkg::seg_ptr_t seg_ptr_r;
    egr_types_pkg::wd_cnt_t  wd_cnt_r;

    // Current word index, ends at wd_cnt for the control word
    egr_types_pkg::wd_cnt_t  word_cnt_r;

    logic last_data;
    logic accepted;

    assign last_data = (word_cnt_r == wd_cnt_r - egr_types_pkg::wd_cnt_t'(1));
    assign accepted  = rreq_valid && rreq_ready;

    // --------------------
    // Handshakes
    assign grant_ready = (state_r == egr_cfg_pkg::wait_fetch);
    // Grant implies a non-empty queue, so the head tag is there
    assign pop         = (state_r == egr_cfg_pkg::get_tag);
    assign pop_queue   = queue_r;

    assign rreq_valid  = (state_r == egr_cfg_pkg::fetch_data) ||
                         (state_r == egr_cfg_pkg::fetch_ctrl);
    assign word_done   = accepted;
    assign pkt_done    = accepted && (state_r == egr_cfg_pkg::fetch_ctrl);

    // Request built from registers only, steady under back-pressure
    always_comb begin
        rreq.seg_ptr   = seg_ptr_r;
        rreq.wd_sel    = word_cnt_r;
        rreq.word_type = (state_r == egr_cfg_pkg::fetch_ctrl) ?
                         egr_types_pkg::word_ctrl : egr_types_pkg::word_data;
        rreq.queue     = queue_r;
        // Markers on data words only
        rreq.sop       = (state_r == egr_cfg_pkg::fetch_data) && (word_cnt_r == '0);
        rreq.eop       = (state_r == egr_cfg_pkg::fetch_data) && last_data;
    end

    // --------------------
    // State machine
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_r    <= egr_cfg_pkg::wait_fetch;
            word_cnt_r <= '0;
        end else begin
            case (state_r)
                egr_cfg_pkg::wait_fetch: begin
                    if (grant_valid) begin
                        state_r <= egr_cfg_pkg::get_tag;
                    end
                end
                egr_cfg_pkg::get_tag: begin
                    word_cnt_r <= '0;
                    state_r    <= egr_cfg_pkg::fetch_data;
                end
                egr_cfg_pkg::fetch_data: begin
                    // Counter steps onto wd_cnt after the last data word
                    if (rreq_ready) begin
                        word_cnt_r <= word_cnt_r + egr_types_pkg::wd_cnt_t'(1);
                        if (last_data) begin
                            state_r <= egr_cfg_pkg::fetch_ctrl;
                        end
                    end
                end
                egr_cfg_pkg::fetch_ctrl: begin
                    if (rreq_ready) begin
                        state_r <= egr_cfg_pkg::wait_fetch;
                    end
                end
                default: state_r <= egr_cfg_pkg::wait_fetch;
            endcase
        end
    end

    // Packet context capture
    always_ff @(posedge clk) begin
        if (grant_valid && grant_ready) begin
            queue_r <= grant_queue;
        end
        if (pop) begin
            seg_ptr_r <= head_tag.seg_ptr;
            wd_cnt_r  <= head_tag.wd_cnt;
        end
    end

endmodule

`default_nettype wire

//--- egr_regs.sv
// APB register block for the egress fetch path
// Queue enable mask, read-only packet and word counters
`timescale 1ns/1ps
`default_nettype none

module egr_regs (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     psel,
    input  wire logic                     penable,
    input  wire logic                     pwrite,
    input  wire egr_types_pkg::apb_addr_t paddr,
    input  wire egr_types_pkg::apb_data_t pwdata,
    output egr_types_pkg::apb_data_t      prdata,
    output logic                          pready,
    output logic                          pslverr,
    input  wire logic                     pkt_done,
    input  wire logic                     word_done,
    output egr_types_pkg::qmask_t         qen
);

    egr_types_pkg::qmask_t    qen_r;
    egr_types_pkg::stat_cnt_t pkt_cnt_r;
    egr_types_pkg::stat_cnt_t word_cnt_r;

    logic access;
    logic hit_qen;
    logic hit_cnt;

    // --------------------
    // Address decode
    assign access  = psel && penable;
    assign hit_qen = (paddr == egr_cfg_pkg::REG_QEN);
    assign hit_cnt = (paddr == egr_cfg_pkg::REG_PKT_CNT) ||
                     (paddr == egr_cfg_pkg::REG_WORD_CNT);

    // No wait states
    assign pready  = 1'b1;
    // Unknown offset, or a write to a read-only counter
    assign pslverr = access && (!(hit_qen || hit_cnt) || (pwrite && hit_cnt));
    assign qen     = qen_r;

    always_comb begin
        case (paddr)
            egr_cfg_pkg::REG_QEN:      prdata = egr_types_pkg::apb_data_t'(qen_r);
            egr_cfg_pkg::REG_PKT_CNT:  prdata = egr_types_pkg::apb_data_t'(pkt_cnt_r);
            egr_cfg_pkg::REG_WORD_CNT: prdata = egr_types_pkg::apb_data_t'(word_cnt_r);
            default:                   prdata = '0;
        endcase
    end

    // --------------------
    // Enable mask
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            qen_r <= egr_cfg_pkg::QEN_RESET;
        end else if (access && pwrite && hit_qen) begin
            qen_r <= pwdata[egr_cfg_pkg::QUEUE_COUNT-1:0];
        end
    end

    // Statistics, wrap at 16 bits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pkt_cnt_r  <= '0;
            word_cnt_r <= '0;
        end else begin
            if (pkt_done) begin
                pkt_cnt_r <= pkt_cnt_r + 1'b1;
            end
            if (word_done) begin
                word_cnt_r <= word_cnt_r + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- egr_top.sv
// Egress packet fetch path top level
// Tag unit, fetch scheduler, packet read controller, APB registers
`timescale 1ns/1ps
`default_nettype none

module egr_top (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    // Tag push
    input  wire egr_types_pkg::tag_t      tag_in,
    input  wire logic                     tag_valid,
    output logic                          tag_ready,
    // Memory read requests
    output egr_types_pkg::rreq_t          rreq,
    output logic                          rreq_valid,
    input  wire logic                     rreq_ready,
    // APB
    input  wire logic                     psel,
    input  wire logic                     penable,
    input  wire logic                     pwrite,
    input  wire egr_types_pkg::apb_addr_t paddr,
    input  wire egr_types_pkg::apb_data_t pwdata,
    output egr_types_pkg::apb_data_t      prdata,
    output logic                          pready,
    output logic                          pslverr
);

    // --------------------
    // Internal nets
    egr_types_pkg::qmask_t nonempty;
    egr_types_pkg::qmask_t qen;
    egr_types_pkg::tag_t   head_tag;
    egr_types_pkg::queue_t pop_queue;
    egr_types_pkg::queue_t grant_queue;
    logic                  pop;
    logic                  grant_valid;
    logic                  grant_ready;
    logic                  pkt_done;
    logic                  word_done;

    egr_tag_unit tag_unit_i (
        .clk, .rst_n, .tag_in, .tag_valid, .tag_ready,
        .nonempty, .pop, .pop_queue, .head_tag
    );

    egr_fetch_sched fetch_sched_i (
        .clk, .rst_n, .nonempty, .qen,
        .grant_valid, .grant_queue, .grant_ready
    );

    prc prc_i (
        .clk, .rst_n, .grant_valid, .grant_queue, .grant_ready,
        .pop, .pop_queue, .head_tag,
        .rreq, .rreq_valid, .rreq_ready, .pkt_done, .word_done
    );

    egr_regs regs_i (
        .clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr, .pkt_done, .word_done, .qen
    );

endmodule

`default_nettype wire

//--- egr_checker.sv
// Scoreboard for the egress fetch path
// Compares accepted read requests and APB responses with expected values
// Tag to first request latency, one result line per test
`timescale 1ns/1ps
`default_nettype none

module egr_checker (
    input wire logic                     clk,
    input wire logic                     rst_n,
    input wire logic                     tag_valid,
    input wire logic                     tag_ready,
    input wire egr_types_pkg::rreq_t     rreq,
    input wire logic                     rreq_valid,
    input wire logic                     rreq_ready,
    input wire logic                     psel,
    input wire logic                     penable,
    input wire egr_types_pkg::apb_data_t prdata,
    input wire logic                     pready,
    input wire logic                     pslverr
);

    typedef struct packed {
        logic                     rd;
        egr_types_pkg::apb_data_t data;
        logic                     err;
    } apb_exp_t;

    // Expected traffic filled by the testbench
    egr_types_pkg::rreq_t exp_req [$];
    apb_exp_t             exp_apb [$];

    int n_pass = 0;
    int n_fail = 0;
    int errors = 0;
    int cycle = 0;
    int push_cyc = 0;
    // Negative when no latency check is armed
    int exp_lat = -1;

    function automatic int pending();
        return exp_req.size();
    endfunction

    task automatic add_req(input egr_types_pkg::rreq_t r);
        exp_req.push_back(r);
    endtask

    task automatic add_apb(input logic rd, input egr_types_pkg::apb_data_t data, input logic err);
        apb_exp_t e;
        e.rd   = rd;
        e.data = data;
        e.err  = err;
        exp_apb.push_back(e);
    endtask

    task automatic arm_latency(input int cycles);
        exp_lat = cycles;
    endtask

    task automatic check_field(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            $display("mismatch at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, want);
            errors++;
        end
    endtask

    // --------------------
    // Leftover expectations at the end of a test count as errors
    task automatic end_test(input string name);
        if (exp_req.size() != 0) begin
            $display("test %s: %0d expected read requests never came", name, exp_req.size());
            errors++;
        end
        if (exp_apb.size() != 0) begin
            $display("test %s: %0d expected APB accesses never happened", name, exp_apb.size());
            errors++;
        end
        if (exp_lat >= 0) begin
            $display("test %s: no read request seen for the latency check", name);
            errors++;
        end
        if (errors == 0) begin
            $display("test %s: passed", name);
            n_pass++;
        end else begin
            $display("test %s: failed with %0d errors", name, errors);
            n_fail++;
        end
        errors  = 0;
        exp_lat = -1;
        exp_req.delete();
        exp_apb.delete();
    endtask

    // --------------------
    // Port monitor sampling what the DUT sees on the same edge
    always @(posedge clk) begin
        egr_types_pkg::rreq_t want;
        apb_exp_t             acc;
        if (rst_n) begin
            cycle++;
            if (tag_valid && tag_ready) begin
                push_cyc = cycle;
            end
            // First valid cycle after the armed push
            if (rreq_valid && exp_lat >= 0) begin
                if (cycle - push_cyc != exp_lat) begin
                    $display("first read request came %0d cycles after its tag, expected %0d",
                             cycle - push_cyc, exp_lat);
                    errors++;
                end
                exp_lat = -1;
            end
            if (rreq_valid && rreq_ready) begin
                if (exp_req.size() == 0) begin
                    $display("read request at %0t was not expected", $time);
                    errors++;
                end else begin
                    want = exp_req.pop_front();
                    check_field("rreq.queue", 32'(rreq.queue), 32'(want.queue));
                    check_field("rreq.seg_ptr", 32'(rreq.seg_ptr), 32'(want.seg_ptr));
                    check_field("rreq.wd_sel", 32'(rreq.wd_sel), 32'(want.wd_sel));
                    check_field("rreq.word_type", 32'(rreq.word_type), 32'(want.word_type));
                    check_field("rreq.sop", 32'(rreq.sop), 32'(want.sop));
                    check_field("rreq.eop", 32'(rreq.eop), 32'(want.eop));
                end
            end
            // APB access phase
            if (psel && penable) begin
                if (exp_apb.size() == 0) begin
                    $display("APB access at %0t was not expected", $time);
                    errors++;
                end else begin
                    acc = exp_apb.pop_front();
                    // No wait states, every access completes in its access phase
                    check_field("pready", 32'(pready), 32'(1'b1));
                    check_field("pslverr", 32'(pslverr), 32'(acc.err));
                    if (acc.rd) begin
                        check_field("prdata", prdata, acc.data);
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- egr_asserts.sv
// Handshake assertions for the packet read controller
// Request hold under back-pressure, pop after grant, one packet at a time
`timescale 1ns/1ps
`default_nettype none

module egr_asserts (
    input wire logic                    clk,
    input wire logic                    rst_n,
    input wire egr_cfg_pkg::prc_state_t state,
    input wire logic                    grant_valid,
    input wire logic                    grant_ready,
    input wire egr_types_pkg::queue_t   grant_queue,
    input wire logic                    pop,
    input wire egr_types_pkg::queue_t   pop_queue,
    input wire egr_types_pkg::rreq_t    rreq,
    input wire logic                    rreq_valid,
    input wire logic                    rreq_ready,
    input wire logic                    pkt_done
);

    // Request holds until the memory side takes it
    rreq_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        (rreq_valid && !rreq_ready) |=> (rreq_valid && $stable(rreq))
    ) else $error("read request changed while waiting for ready");

    // Head tag leaves its FIFO one cycle after the grant, from the granted queue
    pop_after_grant: assert property (
        @(posedge clk) disable iff (!rst_n)
        pop |-> ($past(grant_valid && grant_ready) && pop_queue == $past(grant_queue))
    ) else $error("tag pop without a matching grant accepted on the cycle before");

    // New grants are taken only after the control word of the packet went out
    idle_after_done: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == egr_cfg_pkg::wait_fetch && $past(state) != egr_cfg_pkg::wait_fetch)
            |-> $past(pkt_done)
    ) else $error("controller took grants again before its packet was done");

endmodule

bind prc egr_asserts prc_asserts_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .state       (state_r),
    .grant_valid (grant_valid),
    .grant_ready (grant_ready),
    .grant_queue (grant_queue),
    .pop         (pop),
    .pop_queue   (pop_queue),
    .rreq        (rreq),
    .rreq_valid  (rreq_valid),
    .rreq_ready  (rreq_ready),
    .pkt_done    (pkt_done)
);

`default_nettype wire

//--- egr_tb.sv
// Testbench for the egress fetch path
// Clock, reset, pattern file reader, tag push and APB drivers
// Random read back-pressure, watchdog and closing summary
`timescale 1ns/1ps
`default_nettype none

module egr_tb;

    logic                     clk;
    logic                     rst_n;
    egr_types_pkg::tag_t      tag_in;
    logic                     tag_valid;
    logic                     tag_ready;
    egr_types_pkg::rreq_t     rreq;
    logic                     rreq_valid;
    logic                     rreq_ready;
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    egr_types_pkg::apb_addr_t paddr;
    egr_types_pkg::apb_data_t pwdata;
    egr_types_pkg::apb_data_t prdata;
    logic                     pready;
    logic                     pslverr;

    logic bp_en;
    int   line_cnt;
    int   setup_err;

    egr_top egr_top_i (.*);

    egr_checker chk_i (
        .clk, .rst_n, .tag_valid, .tag_ready, .rreq, .rreq_valid, .rreq_ready,
        .psel, .penable, .prdata, .pready, .pslverr
    );

    // 8 ns period
    always #4 clk = ~clk;

    // Random back-pressure with ready about two cycles in three
    initial begin
        void'($urandom(75));
        forever begin
            @(negedge clk);
            if (bp_en) begin
                rreq_ready = ($urandom % 3) != 0;
            end else begin
                rreq_ready = 1'b1;
            end
        end
    end

    // --------------------
    // Drivers start and end on a falling edge
    task automatic push_tag(input logic [31:0] q, input logic [31:0] ptr, input logic [31:0] cnt);
        tag_in.queue   = egr_types_pkg::queue_t'(q);
        tag_in.seg_ptr = egr_types_pkg::seg_ptr_t'(ptr);
        tag_in.wd_cnt  = egr_types_pkg::wd_cnt_t'(cnt);
        tag_valid      = 1'b1;
        @(posedge clk);
        while (!tag_ready) begin
            @(posedge clk);
        end
        @(negedge clk);
        tag_valid = 1'b0;
    endtask

    task automatic apb_access(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                              input logic [31:0] err);
        chk_i.add_apb(!wr, data, err[0]);
        psel   = 1'b1;
        pwrite = wr;
        paddr  = egr_types_pkg::apb_addr_t'(addr);
        pwdata = wr ? data : '0;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // Wait until every expected request has gone out, then stay quiet a while
    task automatic wait_drain(input int quiet);
        while (chk_i.pending() != 0) begin
            @(negedge clk);
        end
        repeat (quiet) @(negedge clk);
    endtask

    // --------------------
    // Main sequence
    initial begin
        string                lines [$];
        string                line;
        string                cmd;
        string                name;
        logic [31:0]          a, b, c, d, e, g;
        int                   fd;
        logic                 in_test;
        egr_types_pkg::rreq_t r;
        clk       = 1'b0;
        rst_n     = 1'b0;
        tag_in    = '0;
        tag_valid = 1'b0;
        rreq_ready = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        bp_en     = 1'b0;
        in_test   = 1'b0;
        setup_err = 0;
        fd = $fopen("egr_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open egr_patterns.txt");
            setup_err++;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) > 0) begin
                    lines.push_back(line);
                end
            end
            $fclose(fd);
        end
        line_cnt = lines.size();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < lines.size(); i++) begin
            line = lines[i];
            if (line.len() < 2 || line.substr(0, 0) == "#") begin
                continue;
            end
            void'($sscanf(line, "%s %h %h %h %h %h %h", cmd, a, b, c, d, e, g));
            if (cmd == "test") begin
                if (in_test) begin
                    wait_drain(4);
                    chk_i.end_test(name);
                end
                void'($sscanf(line, "%s %s %h", cmd, name, a));
                bp_en   = a[0];
                in_test = 1'b1;
            end else if (cmd == "lat") begin
                chk_i.arm_latency(int'(a));
            end else if (cmd == "push") begin
                push_tag(a, b, c);
            end else if (cmd == "req") begin
                r.queue     = egr_types_pkg::queue_t'(a);
                r.seg_ptr   = egr_types_pkg::seg_ptr_t'(b);
                r.wd_sel    = egr_types_pkg::wd_cnt_t'(c);
                r.word_type = egr_types_pkg::word_type_t'(d[0]);
                r.sop       = e[0];
                r.eop       = g[0];
                chk_i.add_req(r);
            end else if (cmd == "apbw" || cmd == "apbr") begin
                apb_access(cmd == "apbw", a, b, c);
            end else if (cmd == "idle") begin
                wait_drain(int'(a));
            end else begin
                $display("unknown pattern command %s on line %0d", cmd, i + 1);
                setup_err++;
            end
        end
        if (in_test) begin
            wait_drain(4);
            chk_i.end_test(name);
        end
        $display("tests passed %0d failed %0d", chk_i.n_pass, chk_i.n_fail);
        if (chk_i.n_fail == 0 && chk_i.n_pass != 0 && setup_err == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Watchdog allows 200 cycles per pattern line
    initial begin
        @(posedge rst_n);
        repeat ((line_cnt + 1) * 200) @(posedge clk);
        $display("timeout at %0t, the run did not finish in %0d cycles", $time,
                 (line_cnt + 1) * 200);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
egr_cfg_pkg.sv
egr_types_pkg.sv
egr_tag_unit.sv
egr_fetch_sched.sv
prc.sv
egr_regs.sv
egr_top.sv
egr_checker.sv
egr_asserts.sv
egr_tb.sv

//--- Makefile
# Verilator build and run of the egress fetch path testbench

SRCS := $(shell grep -v '^+' vlog.f)

# Rebuilt only when a source or the file list changes
obj_dir/Vegr_tb: vlog.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module egr_tb -f vlog.f

run: obj_dir/Vegr_tb
	obj_dir/Vegr_tb 2>&1 | tee sim.log
	@if grep -q "SOME TESTS FAILED" sim.log || ! grep -q "ALL TESTS PASSED" sim.log; then \
		echo "simulation failed, see sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

//--- egr_patterns.txt
# test <name> <random back-pressure>, lat <cycles>, push <queue> <seg_ptr> <wd_cnt>, idle <cycles>
# req <queue> <seg_ptr> <wd_sel> <word_type> <sop> <eop>, apbw|apbr <addr> <data> <pslverr>, hex
test single_packet 0
req 0 100 0 0 1 0
req 0 100 1 0 0 0
req 0 100 2 0 0 1
req 0 100 3 1 0 0
lat 3
push 0 100 3
test round_robin 1
req 0 200 0 0 1 0
req 0 200 1 0 0 1
req 0 200 2 1 0 0
req 1 210 0 0 1 1
req 1 210 1 1 0 0
req 2 220 0 0 1 1
req 2 220 1 1 0 0
req 3 230 0 0 1 1
req 3 230 1 1 0 0
req 1 211 0 0 1 1
req 1 211 1 1 0 0
push 0 200 2
push 1 210 1
push 2 220 1
push 3 230 1
push 1 211 1
test back_pressure 1
req 2 300 0 0 1 0
req 2 300 1 0 0 0
req 2 300 2 0 0 1
req 2 300 3 1 0 0
req 3 310 0 0 1 0
req 3 310 1 0 0 1
req 3 310 2 1 0 0
push 2 300 3
push 3 310 2
test queue_enable 1
apbw 0 b 0
req 3 410 0 0 1 1
req 3 410 1 1 0 0
push 2 400 1
push 3 410 1
idle 20
req 2 400 0 0 1 1
req 2 400 1 1 0 0
apbw 0 f 0
test apb_counters 0
apbr 0 f 0
apbr 4 a 0
apbr 8 1a 0
apbw 4 1 1
apbr 4 a 0
apbw c 0 1
apbr c 0 1
